// ==== all.f ====
+incdir+include
design/mem_map_pkg.sv
design/dl_pkg.sv
design/dl_addr_map.sv
design/media_status.sv
design/mem_request_mux.sv
design/read_data_shaper.sv
design/reset_stretcher.sv
design/mac_mem_top.sv
sim/tb_mac_mem.sv

// ==== design/dl_addr_map.sv ====
module dl_addr_map (
	input  logic                  clk32,
	input  logic                  rst_i,
	input  logic                  dl_wr_i,
	input  dl_pkg::dl_write_t     dl_i,
	output mem_map_pkg::mem_req_t dl_req_o,
	output logic                  dl_req_vld_o
);

	mem_map_pkg::word_ofs_t region_base;
	mem_map_pkg::word_ofs_t word_addr;
	mem_map_pkg::mem_req_t  req_next;
	logic                   index_ok;

	// ----------------------------------------------------------------------
	// region select
	// ----------------------------------------------------------------------

	always_comb begin
		index_ok    = 1'b1;
		region_base = mem_map_pkg::ROM_WORD_BASE;
		case (dl_i.index)
			dl_pkg::IDX_ROM: begin
				region_base = mem_map_pkg::ROM_WORD_BASE;
			end
			dl_pkg::IDX_DISK1: begin
				region_base = mem_map_pkg::DISK1_WORD_BASE;
			end
			dl_pkg::IDX_DISK2: begin
				region_base = mem_map_pkg::DISK2_WORD_BASE;
			end
			default: begin
				// pram and anything else stays off the memory port
				index_ok = 1'b0;
			end
		endcase
	end

	// loader counts bytes, sdram counts words
	assign word_addr = dl_i.addr[21:1] + region_base;

	always_comb begin
		req_next.addr  = {mem_map_pkg::DL_REGION_TAG, word_addr};
		req_next.data  = {dl_i.data, dl_i.data};
		// even byte goes to the upper lane
		req_next.lanes = {~dl_i.addr[0], dl_i.addr[0]};
		req_next.we    = 1'b1;
		req_next.oe    = 1'b0;
	end

	// ----------------------------------------------------------------------
	// output register
	// ----------------------------------------------------------------------

	always_ff @(posedge clk32) begin
		if (rst_i) begin
			dl_req_vld_o <= 1'b0;
		end else begin
			dl_req_vld_o <= dl_wr_i && index_ok;
		end
	end

	always_ff @(posedge clk32) begin
		if (dl_wr_i && index_ok) begin
			dl_req_o <= req_next;
		end
	end

	a_dl_req_is_write: assert property (@(posedge clk32) disable iff (rst_i)
		dl_req_vld_o |-> (dl_req_o.we && !dl_req_o.oe));

endmodule

// ==== design/dl_pkg.sv ====
package dl_pkg;

	// ----------------------------------------------------------------------
	// loader write channel
	// ----------------------------------------------------------------------

	typedef logic [4:0]  dl_index_t;
	typedef logic [23:0] dl_addr_t;
	typedef logic [7:0]  dl_byte_t;

	typedef struct packed {
		dl_index_t index;
		dl_addr_t  addr;
		dl_byte_t  data;
	} dl_write_t;

	// download targets
	localparam dl_index_t IDX_ROM   = 5'd0;
	localparam dl_index_t IDX_DISK1 = 5'd1;
	localparam dl_index_t IDX_DISK2 = 5'd2;

	// ----------------------------------------------------------------------
	// image sizes
	// ----------------------------------------------------------------------

	// word index of the last byte, i.e. byte address bits 23..1
	typedef logic [22:0] dl_word_idx_t;

	// 819200 byte image, two sides
	localparam dl_word_idx_t DS_LAST_WORD = 23'd409599;
	// 409600 byte image, one side
	localparam dl_word_idx_t SS_LAST_WORD = 23'd204799;

	// 0..3 for 64K, 128K, 256K, 512K
	typedef logic [1:0] rom_size_t;

	// system reset hold after the last cause
	typedef logic [15:0] hold_cnt_t;
	localparam hold_cnt_t RESET_HOLD = 16'd65535;

endpackage

// ==== design/mac_mem_top.sv ====
module mac_mem_top (
	input  logic                   clk32,
	input  logic                   rst_i,

	// loader
	input  logic                   dl_wr_i,
	input  logic                   dl_active_i,
	input  dl_pkg::dl_write_t      dl_i,

	// chipset and memory
	input  mem_map_pkg::cpu_req_t  cpu_req_i,
	output mem_map_pkg::mem_req_t  mem_req_o,
	input  mem_map_pkg::mem_word_t mem_rdata_i,
	input  logic                   disk_read_i,
	output mem_map_pkg::mem_word_t cpu_rdata_o,

	// floppy and rom status
	input  logic [1:0]             eject_i,
	output logic [1:0]             disk_inserted_o,
	output logic [1:0]             disk_double_o,
	output dl_pkg::rom_size_t      rom_size_o,
	output logic                   machine_se_o,

	// system reset
	input  logic                   reset_req_i,
	input  logic                   mem_4mb_i,
	output logic                   sys_reset_n_o
);

	mem_map_pkg::mem_req_t dl_req;
	logic                  dl_req_vld;
	logic                  dl_cycle;

	// ----------------------------------------------------------------------
	// memory pipeline
	// ----------------------------------------------------------------------

	dl_addr_map u_dl_addr_map (
		.clk32        (clk32),
		.rst_i        (rst_i),
		.dl_wr_i      (dl_wr_i),
		.dl_i         (dl_i),
		.dl_req_o     (dl_req),
		.dl_req_vld_o (dl_req_vld)
	);

	mem_request_mux u_mem_request_mux (
		.clk32        (clk32),
		.rst_i        (rst_i),
		.dl_active_i  (dl_active_i),
		.dl_req_i     (dl_req),
		.dl_req_vld_i (dl_req_vld),
		.cpu_req_i    (cpu_req_i),
		.mem_req_o    (mem_req_o),
		.dl_cycle_o   (dl_cycle)
	);

	read_data_shaper u_read_data_shaper (
		.clk32       (clk32),
		.rst_i       (rst_i),
		.dl_cycle_i  (dl_cycle),
		.disk_read_i (disk_read_i),
		.byte_sel_i  (cpu_req_i.addr[0]),
		.mem_rdata_i (mem_rdata_i),
		.cpu_rdata_o (cpu_rdata_o)
	);

	// side blocks watching the loader
	media_status u_media_status (
		.clk32           (clk32),
		.rst_i           (rst_i),
		.dl_wr_i         (dl_wr_i),
		.dl_active_i     (dl_active_i),
		.dl_i            (dl_i),
		.eject_i         (eject_i),
		.disk_inserted_o (disk_inserted_o),
		.disk_double_o   (disk_double_o),
		.rom_size_o      (rom_size_o),
		.machine_se_o    (machine_se_o)
	);

	reset_stretcher u_reset_stretcher (
		.clk32         (clk32),
		.rst_i         (rst_i),
		.reset_req_i   (reset_req_i),
		.dl_active_i   (dl_active_i),
		.dl_index_i    (dl_i.index),
		.mem_4mb_i     (mem_4mb_i),
		.sys_reset_n_o (sys_reset_n_o)
	);

endmodule

// ==== design/media_status.sv ====
module media_status (
	input  logic              clk32,
	input  logic              rst_i,
	input  logic              dl_wr_i,
	input  logic              dl_active_i,
	input  dl_pkg::dl_write_t dl_i,
	input  logic [1:0]        eject_i,
	output logic [1:0]        disk_inserted_o,
	output logic [1:0]        disk_double_o,
	output dl_pkg::rom_size_t rom_size_o,
	output logic              machine_se_o
);

	dl_pkg::dl_addr_t last_addr;
	logic             dl_active_q;
	logic             dl_end;
	logic             is_double;
	logic             is_single;
	logic [1:0]       disk_hit;
	logic [1:0]       disk_single;

	// address of the most recent strobe is the image size minus one
	always_ff @(posedge clk32) begin
		if (dl_wr_i) begin
			last_addr <= dl_i.addr;
		end
	end

	always_ff @(posedge clk32) begin
		if (rst_i) begin
			dl_active_q <= 1'b0;
		end else begin
			dl_active_q <= dl_active_i;
		end
	end

	assign dl_end    = dl_active_q && !dl_active_i;
	assign is_double = (last_addr[23:1] == dl_pkg::DS_LAST_WORD);
	assign is_single = (last_addr[23:1] == dl_pkg::SS_LAST_WORD);
	assign disk_hit  = {dl_i.index == dl_pkg::IDX_DISK2, dl_i.index == dl_pkg::IDX_DISK1};

	// ----------------------------------------------------------------------
	// per drive classification
	// ----------------------------------------------------------------------

	always_ff @(posedge clk32) begin
		if (rst_i) begin
			disk_double_o <= 2'b00;
			disk_single   <= 2'b00;
		end else begin
			for (int n = 0; n < 2; n++) begin
				// eject wins over a finishing download
				if (eject_i[n]) begin
					disk_double_o[n] <= 1'b0;
					disk_single[n]   <= 1'b0;
				end else if (dl_end && disk_hit[n]) begin
					disk_double_o[n] <= is_double;
					disk_single[n]   <= is_single;
				end
			end
		end
	end

	assign disk_inserted_o = disk_double_o | disk_single;

	// rom size from the highest address bits seen
	always_ff @(posedge clk32) begin
		if (rst_i) begin
			rom_size_o <= '0;
		end else if (dl_wr_i && dl_i.index == dl_pkg::IDX_ROM) begin
			rom_size_o <= {dl_i.addr[18] | dl_i.addr[17],
				dl_i.addr[18] | (dl_i.addr[16] & ~dl_i.addr[17])};
		end
	end

	// 256K and up means an SE rom
	assign machine_se_o = rom_size_o[1];

	a_sides_exclusive: assert property (@(posedge clk32) disable iff (rst_i)
		(disk_double_o & disk_single) == 2'b00);

endmodule

// ==== design/mem_map_pkg.sv ====
package mem_map_pkg;

	// ----------------------------------------------------------------------
	// sdram word space and chipset bus widths
	// ----------------------------------------------------------------------

	typedef logic [24:0] mem_addr_t;
	typedef logic [15:0] mem_word_t;

	// chipset byte address, bit 0 picks the byte
	typedef logic [21:0] cpu_addr_t;

	// byte enables, upper bit is the upper byte
	typedef logic [1:0]  mem_lanes_t;

	typedef logic [20:0] word_ofs_t;
	typedef logic [3:0]  region_tag_t;

	// ----------------------------------------------------------------------
	// region layout
	// ----------------------------------------------------------------------

	// every loader word sits under this tag
	localparam region_tag_t DL_REGION_TAG   = 4'd1;

	// rom first, disk images after it
	localparam word_ofs_t   ROM_WORD_BASE   = 21'h000000;
	localparam word_ofs_t   DISK1_WORD_BASE = 21'h080000;
	localparam word_ofs_t   DISK2_WORD_BASE = 21'h100000;

	typedef struct packed {
		cpu_addr_t addr;
		logic      rom_sel;
		logic      uds;
		logic      lds;
		logic      we;
		logic      oe;
	} cpu_req_t;

	typedef struct packed {
		mem_addr_t  addr;
		mem_word_t  data;
		mem_lanes_t lanes;
		logic       we;
		logic       oe;
	} mem_req_t;

	localparam mem_req_t MEM_REQ_IDLE = '0;

endpackage

// ==== design/mem_request_mux.sv ====
module mem_request_mux (
	input  logic                  clk32,
	input  logic                  rst_i,
	input  logic                  dl_active_i,
	input  mem_map_pkg::mem_req_t dl_req_i,
	input  logic                  dl_req_vld_i,
	input  mem_map_pkg::cpu_req_t cpu_req_i,
	output mem_map_pkg::mem_req_t mem_req_o,
	output logic                  dl_cycle_o
);

	mem_map_pkg::mem_req_t cpu_mapped;
	mem_map_pkg::mem_req_t req_next;

	// chipset side, rom select sits just above the word address
	always_comb begin
		cpu_mapped.addr  = {3'b000, cpu_req_i.rom_sel, cpu_req_i.addr[21:1]};
		cpu_mapped.data  = '0;
		cpu_mapped.lanes = {cpu_req_i.uds, cpu_req_i.lds};
		cpu_mapped.we    = cpu_req_i.we;
		cpu_mapped.oe    = cpu_req_i.oe;
	end

	// a pending loader word always goes out, even right after the download ends
	always_comb begin
		if (dl_req_vld_i) begin
			req_next = dl_req_i;
		end else if (dl_active_i) begin
			req_next = mem_map_pkg::MEM_REQ_IDLE;
		end else begin
			req_next = cpu_mapped;
		end
	end

	// ----------------------------------------------------------------------
	// memory port register
	// ----------------------------------------------------------------------

	always_ff @(posedge clk32) begin
		if (rst_i) begin
			mem_req_o  <= mem_map_pkg::MEM_REQ_IDLE;
			dl_cycle_o <= 1'b0;
		end else begin
			mem_req_o  <= req_next;
			dl_cycle_o <= dl_active_i;
		end
	end

	a_no_read_write: assert property (@(posedge clk32) disable iff (rst_i)
		!(mem_req_o.we && mem_req_o.oe));

endmodule

// ==== design/read_data_shaper.sv ====
module read_data_shaper (
	input  logic                   clk32,
	input  logic                   rst_i,
	input  logic                   dl_cycle_i,
	input  logic                   disk_read_i,
	input  logic                   byte_sel_i,
	input  mem_map_pkg::mem_word_t mem_rdata_i,
	output mem_map_pkg::mem_word_t cpu_rdata_o
);

	logic [7:0]             sel_byte;
	mem_map_pkg::mem_word_t rdata_next;

	// odd address takes the low byte
	assign sel_byte = byte_sel_i ? mem_rdata_i[7:0] : mem_rdata_i[15:8];

	// screen reads all ones while the loader owns the memory
	always_comb begin
		if (dl_cycle_i) begin
			rdata_next = 16'hFFFF;
		end else if (disk_read_i) begin
			// disk images are byte wide
			rdata_next = {sel_byte, sel_byte};
		end else begin
			rdata_next = mem_rdata_i;
		end
	end

	always_ff @(posedge clk32) begin
		if (rst_i) begin
			cpu_rdata_o <= '0;
		end else begin
			cpu_rdata_o <= rdata_next;
		end
	end

endmodule

// ==== design/reset_stretcher.sv ====
module reset_stretcher (
	input  logic              clk32,
	input  logic              rst_i,
	input  logic              reset_req_i,
	input  logic              dl_active_i,
	input  dl_pkg::dl_index_t dl_index_i,
	input  logic              mem_4mb_i,
	output logic              sys_reset_n_o
);

	dl_pkg::hold_cnt_t hold_cnt;
	logic              mem_4mb_q;
	logic              rom_loading;
	logic              mem_changed;
	logic              reset_cause;

	// memory size as seen last cycle
	always_ff @(posedge clk32) begin
		mem_4mb_q <= mem_4mb_i;
	end

	assign rom_loading = dl_active_i && (dl_index_i == dl_pkg::IDX_ROM);
	assign mem_changed = (mem_4mb_i != mem_4mb_q);

	// ----------------------------------------------------------------------
	// hold counter
	// ----------------------------------------------------------------------

	assign reset_cause = rst_i || reset_req_i || rom_loading || mem_changed;

	always_ff @(posedge clk32) begin
		if (reset_cause) begin
			hold_cnt <= dl_pkg::RESET_HOLD;
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// machine runs only once the count has drained
	assign sys_reset_n_o = (hold_cnt == '0);

endmodule

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
	--top-module tb_mac_mem -o tb_mac_mem &&
out="$(./obj_dir/tb_mac_mem)" &&
echo "$out" &&
echo "$out" | grep -qx "SIMULATION PASSED" || exit 1

// ==== include/tb_util.svh ====
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// ----------------------------------------------------------------------
// random source
// ----------------------------------------------------------------------

// galois form, taps for x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsr;

// one step per returned bit, first bit ends up highest
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsr[0]};
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
	end
	return v;
endfunction

// ----------------------------------------------------------------------
// result checking
// ----------------------------------------------------------------------

int check_cnt;
int fail_cnt;

task automatic compare_values(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
	check_cnt++;
	if (actual !== expected) begin
		fail_cnt++;
		$display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
	end
endtask

`endif

// ==== sim/tb_mac_mem.sv ====
module tb_mac_mem;
	timeunit 1ns;
	timeprecision 1ps;

	// two full reset holds, the rest covers the test sequences
	localparam int TIMEOUT_CYCLES = 2 * 65536 + 68928;

	logic                   clk32 = 1'b0;
	logic                   rst_i;
	logic                   dl_wr_i;
	logic                   dl_active_i;
	dl_pkg::dl_write_t      dl_i;
	mem_map_pkg::cpu_req_t  cpu_req_i;
	mem_map_pkg::mem_req_t  mem_req_o;
	mem_map_pkg::mem_word_t mem_rdata_i;
	logic                   disk_read_i;
	mem_map_pkg::mem_word_t cpu_rdata_o;
	logic [1:0]             eject_i;
	logic [1:0]             disk_inserted_o;
	logic [1:0]             disk_double_o;
	dl_pkg::rom_size_t      rom_size_o;
	logic                   machine_se_o;
	logic                   reset_req_i;
	logic                   mem_4mb_i;
	logic                   sys_reset_n_o;

	`include "tb_util.svh"

	int    cycle;
	string test_name;
	logic  chip_noise;
	logic  rst_n_seen;

	// reference model state
	mem_map_pkg::mem_req_t  dl_exp_q[$];
	int                     dl_due_q[$];
	int                     model_cycle;
	logic                   model_ready;
	mem_map_pkg::mem_req_t  exp_req;
	mem_map_pkg::mem_word_t exp_rdata;
	logic [1:0]             exp_double;
	logic [1:0]             exp_single;
	logic [1:0]             exp_rom;
	logic [23:0]            m_last_addr;
	logic                   m_active_q;

	always #10 clk32 = ~clk32;

	mac_mem_top UUT (.*);

	always @(posedge clk32) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES) begin
			$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// reference model, fed with the inputs the next edge will sample
	// ----------------------------------------------------------------------

	task automatic model_step();
		mem_map_pkg::mem_req_t req;
		logic [20:0]           base;
		logic [7:0]            sel;
		logic                  dl_end;
		logic [22:0]           last_word;
		if (dl_wr_i && (dl_i.index <= 5'd2)) begin
			case (dl_i.index)
				5'd0: base = 21'h000000;
				5'd1: base = 21'h080000;
				default: base = 21'h100000;
			endcase
			req.addr  = {4'd1, dl_i.addr[21:1] + base};
			req.data  = {dl_i.data, dl_i.data};
			req.lanes = dl_i.addr[0] ? 2'b01 : 2'b10;
			req.we    = 1'b1;
			req.oe    = 1'b0;
			dl_exp_q.push_back(req);
			dl_due_q.push_back(model_cycle + 2);
		end
		if (dl_due_q.size() > 0 && dl_due_q[0] == model_cycle + 1) begin
			exp_req = dl_exp_q.pop_front();
			dl_due_q.delete(0);
		end else if (dl_active_i) begin
			exp_req = '0;
		end else begin
			exp_req.addr  = {3'b000, cpu_req_i.rom_sel, cpu_req_i.addr[21:1]};
			exp_req.data  = '0;
			exp_req.lanes = {cpu_req_i.uds, cpu_req_i.lds};
			exp_req.we    = cpu_req_i.we;
			exp_req.oe    = cpu_req_i.oe;
		end
		// read path sees the download flag one cycle late
		sel = cpu_req_i.addr[0] ? mem_rdata_i[7:0] : mem_rdata_i[15:8];
		if (m_active_q) begin
			exp_rdata = 16'hFFFF;
		end else if (disk_read_i) begin
			exp_rdata = {sel, sel};
		end else begin
			exp_rdata = mem_rdata_i;
		end
		dl_end    = m_active_q && !dl_active_i;
		last_word = m_last_addr[23:1];
		for (int n = 0; n < 2; n++) begin
			if (eject_i[n]) begin
				exp_double[n] = 1'b0;
				exp_single[n] = 1'b0;
			end else if (dl_end && dl_i.index == 5'(n + 1)) begin
				exp_double[n] = (last_word == 23'd409599);
				exp_single[n] = (last_word == 23'd204799);
			end
		end
		// highest address bit reached gives the rom size
		if (dl_wr_i && dl_i.index == 5'd0) begin
			if (dl_i.addr[18]) begin
				exp_rom = 2'd3;
			end else if (dl_i.addr[17]) begin
				exp_rom = 2'd2;
			end else if (dl_i.addr[16]) begin
				exp_rom = 2'd1;
			end else begin
				exp_rom = 2'd0;
			end
		end
		if (dl_wr_i) begin
			m_last_addr = dl_i.addr;
		end
		m_active_q  = dl_active_i;
		model_cycle++;
		model_ready = 1'b1;
	endtask

	task automatic check_outputs();
		compare_values({test_name, " mem_req_o"}, 64'(exp_req), 64'(mem_req_o));
		compare_values({test_name, " cpu_rdata_o"}, 64'(exp_rdata), 64'(cpu_rdata_o));
		compare_values({test_name, " disk_double_o"}, 64'(exp_double), 64'(disk_double_o));
		compare_values({test_name, " disk_inserted_o"}, 64'(exp_double | exp_single),
			64'(disk_inserted_o));
		compare_values({test_name, " rom_size_o"}, 64'(exp_rom), 64'(rom_size_o));
		compare_values({test_name, " machine_se_o"}, 64'(exp_rom[1]), 64'(machine_se_o));
	endtask

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------

	// check and model at the falling edge, then return on the rising edge
	task automatic tick();
		logic [31:0]           r;
		mem_map_pkg::cpu_req_t cpu;
		@(negedge clk32);
		if (model_ready) begin
			check_outputs();
		end
		model_step();
		rst_n_seen = sys_reset_n_o;
		@(posedge clk32);
		if (chip_noise) begin
			r      = rand_bits(27);
			cpu    = r[26:0];
			cpu.oe = cpu.oe & ~cpu.we;
			cpu_req_i   <= cpu;
			mem_rdata_i <= 16'(rand_bits(16));
			disk_read_i <= rand_bits(1) != 0;
		end
	endtask

	// counts the low samples after the last reset cause
	task automatic measure_hold(output int n);
		n = 0;
		tick();
		while (!rst_n_seen && n < 70000) begin
			n++;
			tick();
		end
	endtask

	task automatic run_download(input logic [4:0] index, input int n_strobes,
			input logic [23:0] last);
		logic [23:0] addr;
		tick();
		dl_active_i <= 1'b1;
		dl_i.index  <= index;
		for (int i = 0; i < n_strobes; i++) begin
			addr = (i == n_strobes - 1) ? last : 24'(rand_bits(24));
			tick();
			dl_wr_i   <= 1'b1;
			dl_i.addr <= addr;
			dl_i.data <= 8'(rand_bits(8));
			// zero gap gives back to back strobes
			repeat (rand_bits(1)) begin
				tick();
				dl_wr_i <= 1'b0;
			end
		end
		tick();
		dl_wr_i     <= 1'b0;
		dl_active_i <= 1'b0;
		// index stays put past the falling edge
		repeat (3) tick();
	endtask

	initial begin
		int hold;
		lfsr        = 32'd4273;
		rst_i       = 1'b1;
		dl_wr_i     = 1'b0;
		dl_active_i = 1'b0;
		dl_i        = '0;
		cpu_req_i   = '0;
		mem_rdata_i = '0;
		disk_read_i = 1'b0;
		eject_i     = 2'b00;
		reset_req_i = 1'b0;
		mem_4mb_i   = 1'b0;
		chip_noise  = 1'b0;
		model_ready = 1'b0;
		model_cycle = 0;
		m_active_q  = 1'b0;
		m_last_addr = '0;
		exp_double  = 2'b00;
		exp_single  = 2'b00;
		exp_rom     = 2'b00;
		repeat (4) @(posedge clk32);
		rst_i <= 1'b0;

		test_name = "reset_hold";
		measure_hold(hold);
		compare_values("reset_hold release", 64'd65535, 64'(hold));
		mem_4mb_i <= ~mem_4mb_i;
		tick();
		compare_values("reset_hold before toggle", 64'd1, 64'(rst_n_seen));
		measure_hold(hold);
		compare_values("reset_hold retrigger", 64'd65535, 64'(hold));

		test_name = "dl_map";
		run_download(5'd0, 20, 24'(rand_bits(24)));
		run_download(5'd1, 20, 24'(rand_bits(24)));
		run_download(5'd2, 20, 24'(rand_bits(24)));
		run_download(5'd7, 20, 24'(rand_bits(24)));

		test_name = "image_class";
		for (int d = 1; d <= 2; d++) begin
			run_download(5'(d), 4, 24'(rand_bits(24)));
			run_download(5'(d), 4, 24'd409599);
			run_download(5'(d), 4, 24'd819199);
			tick();
			eject_i <= 2'(d);
			tick();
			eject_i <= 2'b00;
		end

		test_name = "rom_size";
		repeat (4) run_download(5'd0, 6, 24'(rand_bits(24)));

		test_name = "chipset";
		chip_noise = 1'b1;
		repeat (3000) tick();
		run_download(5'd2, 8, 24'(rand_bits(24)));
		repeat (200) tick();
		chip_noise = 1'b0;
		repeat (4) tick();

		$display("checks %0d, errors %0d", check_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule
